// File: riscv_golden.txt
# P addr word = program, M addr word = initial data, C cycles = run length
# R reg value = expected register, D addr word = expected data word
P 00000000 00500093
P 00000004 ffd00113
P 00000008 002081b3
P 0000000c 40208233
P 00000010 0020f2b3
P 00000014 0020e333
P 00000018 0020c3b3
P 0000001c 00109433
P 00000020 40115493
P 00000024 01c15513
P 00000028 001125b3
P 0000002c 00113633
P 00000030 123456b7
P 00000034 00001717
P 00000038 10000793
P 0000003c 0037a223
P 00000040 0047a803
P 00000044 0007a883
P 00000048 00108663
P 0000004c 00100913
P 00000050 00100993
P 00000054 00109463
P 00000058 00700a13
P 0000005c 00209663
P 00000060 00100a93
P 00000064 00200a93
P 00000068 00208463
P 0000006c 00900b13
P 00000070 00c00bef
P 00000074 00100c13
P 00000078 00200c13
P 0000007c 09000c93
P 00000080 000c8d67
P 00000084 00100d93
P 00000088 00200d93
P 0000008c 00300d93
P 00000090 05500e13
P 00000094 0000006f
M 00000100 deadbeef
C 300
R 1 00000005
R 2 fffffffd
R 3 00000002
R 4 00000008
R 5 00000005
R 6 fffffffd
R 7 fffffff8
R 8 000000a0
R 9 fffffffe
R 10 0000000f
R 11 00000001
R 12 00000000
R 13 12345000
R 14 00001034
R 15 00000100
R 16 00000002
R 17 deadbeef
R 18 00000000
R 19 00000000
R 20 00000007
R 21 00000000
R 22 00000009
R 23 00000074
R 24 00000000
R 25 00000090
R 26 00000084
R 27 00000000
R 28 00000055
D 00000100 deadbeef
D 00000104 00000002

// File: compile.f
riscv_pkg.sv
alu.sv
reg_file.sv
control_decoder.sv
hazard_unit.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
riscv_core.sv
tb_riscv_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wall -Wno-fatal
TOP       ?= tb_riscv_core
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail on reported errors"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_riscv_core.sv
`timescale 1ns/100ps

module tb_riscv_core;

    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam logic [31:0] jal_self = 32'h0000_006f;

    logic                 clk;
    logic                 arst_n;
    logic [31:0]          pc;
    riscv_pkg::instr_t    instr;
    logic [31:0]          mem_addr;
    logic [31:0]          mem_write_data;
    logic                 mem_read_en;
    logic                 mem_write_en;
    logic [31:0]          load_data;
    riscv_pkg::reg_addr_t debug_reg_addr;
    logic [31:0]          debug_reg_data;

    logic [31:0] rom [64];
    logic [31:0] ram [128];
    logic [31:0] ram_init [128];
    logic        ram_written [128];
    logic [31:0] exp_reg [32];
    logic        reg_listed [32];
    logic [31:0] exp_mem [128];
    logic        mem_listed [128];
    int          run_cycles;
    int          errors;
    logic        loaded;
    logic        finished;

    riscv_core #(
        .reset_pc (reset_pc)
    ) DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .pc             (pc),
        .instr          (instr),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_read_en    (mem_read_en),
        .mem_write_en   (mem_write_en),
        .load_data      (load_data),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data)
    );

    // combinational ROM and RAM, RAM writes on the clock edge
    // load data only appears while the core asks for a read
    assign instr     = rom[pc[7:2]];
    assign load_data = mem_read_en ? ram[mem_addr[8:2]] : 32'd0;

    always @(posedge clk) begin
        if (mem_write_en) begin
            ram[mem_addr[8:2]]         <= mem_write_data;
            ram_written[mem_addr[8:2]] <= 1'b1;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Error %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic load_golden();
        int    fd;
        string line;
        byte   tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("riscv_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open riscv_golden.txt");
            $display("Errors: %0d", errors + 1);
            $display("Finished with errors");
            $finish;
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 2 && line[0] != "#") begin
                tag = line[0];
                // register numbers and the cycle count are decimal, the rest hex
                if (tag == "R" || tag == "C") begin
                    void'($sscanf(line, "%c %d %h", tag, a, b));
                end else begin
                    void'($sscanf(line, "%c %h %h", tag, a, b));
                end
                case (tag)
                    "P": rom[a[7:2]] = b;
                    "M": begin
                        ram[a[8:2]]      = b;
                        ram_init[a[8:2]] = b;
                    end
                    "C": run_cycles = a;
                    "R": begin
                        exp_reg[a[4:0]]    = b;
                        reg_listed[a[4:0]] = 1'b1;
                    end
                    "D": begin
                        exp_mem[a[8:2]]    = b;
                        mem_listed[a[8:2]] = 1'b1;
                    end
                    default: begin
                        errors++;
                        $display("unknown tag in golden file: %s", line);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // watchdog sized from the run length in the golden file
    initial begin
        wait (loaded);
        repeat (2 * run_cycles + 50) @(posedge clk);
        if (!finished) begin
            $display("timeout: program never reached its final loop");
            $display("Errors: %0d", errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        errors         = 0;
        loaded         = 1'b0;
        finished       = 1'b0;
        run_cycles     = 1000;
        arst_n         = 1'b0;
        debug_reg_addr = '0;
        for (int i = 0; i < 64; i++) begin
            // nop with the word index in the immediate
            rom[i] = 32'h0000_0013 | (i << 20);
        end
        for (int i = 0; i < 128; i++) begin
            ram[i]         = 32'ha5a5_0000 | (i * 4);
            ram_init[i]    = ram[i];
            ram_written[i] = 1'b0;
            exp_mem[i]     = '0;
            mem_listed[i]  = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            exp_reg[i]    = '0;
            reg_listed[i] = 1'b0;
        end
        load_golden();
        loaded = 1'b1;

        // reset for two cycles
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("reset pc", reset_pc, pc);
            check_value("reset mem_read_en", 32'd0, {31'd0, mem_read_en});
            check_value("reset mem_write_en", 32'd0, {31'd0, mem_write_en});
        end
        arst_n = 1'b1;
        #1;
        check_value("post reset pc", reset_pc, pc);
        check_value("post reset mem_read_en", 32'd0, {31'd0, mem_read_en});
        check_value("post reset mem_write_en", 32'd0, {31'd0, mem_write_en});

        // run until the final jal-to-self is fetched, then drain the pipeline
        do begin
            @(posedge clk);
            #2;
        end while (instr !== jal_self);
        repeat (8) @(posedge clk);

        for (int r = 0; r < 32; r++) begin
            if (reg_listed[r]) begin
                @(posedge clk);
                #1 debug_reg_addr = r[4:0];
                #2 check_value($sformatf("reg x%0d", r), exp_reg[r], debug_reg_data);
            end
        end
        for (int i = 0; i < 128; i++) begin
            if (mem_listed[i]) begin
                check_value($sformatf("ram word %08h", i * 4), exp_mem[i], ram[i]);
            end else begin
                assert (!ram_written[i] && ram[i] === ram_init[i]) else begin
                    errors++;
                    $display("unexpected write to ram word %08h", i * 4);
                end
            end
        end

        finished = 1'b1;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: riscv_core.sv
`timescale 1ns/100ps

module riscv_core #(
    parameter logic [riscv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic [riscv_pkg::xlen-1:0]  pc,
    input  riscv_pkg::instr_t           instr,
    output logic [riscv_pkg::xlen-1:0]  mem_addr,
    output logic [riscv_pkg::xlen-1:0]  mem_write_data,
    output logic                        mem_read_en,
    output logic                        mem_write_en,
    input  logic [riscv_pkg::xlen-1:0]  load_data,
    input  riscv_pkg::reg_addr_t        debug_reg_addr,
    output logic [riscv_pkg::xlen-1:0]  debug_reg_data
);

    // fetch and hazard control
    logic [riscv_pkg::xlen-1:0] dec_pc;
    riscv_pkg::instr_t          dec_instr;
    logic                       pc_write_en;
    logic                       if_kill;
    logic                       dec_kill;
    logic                       br_taken;
    logic [riscv_pkg::xlen-1:0] redirect_pc;

    // decode to execute
    riscv_pkg::reg_addr_t       dec_rd;
    logic                       dec_reg_write;
    logic [riscv_pkg::xlen-1:0] exe_pc;
    logic [riscv_pkg::xlen-1:0] exe_op1;
    logic [riscv_pkg::xlen-1:0] exe_op2;
    logic [riscv_pkg::xlen-1:0] exe_rs2;
    riscv_pkg::alu_op_t         exe_alu_op;
    riscv_pkg::pc_sel_t         exe_pc_sel;
    logic                       exe_is_beq;
    logic                       exe_is_bne;
    riscv_pkg::exe_wb_sel_t     exe_exe_wb_sel;
    riscv_pkg::mem_wb_sel_t     exe_mem_wb_sel;
    logic                       exe_reg_write;
    logic                       exe_mem_read;
    logic                       exe_mem_write;
    riscv_pkg::reg_addr_t       exe_rd;

    // execute to memory, then writeback
    logic [riscv_pkg::xlen-1:0] mem_result;
    logic [riscv_pkg::xlen-1:0] mem_rs2;
    riscv_pkg::reg_addr_t       mem_rd;
    logic                       mem_reg_write;
    logic                       mem_read;
    logic                       mem_write;
    riscv_pkg::mem_wb_sel_t     mem_mem_wb_sel;
    logic [riscv_pkg::xlen-1:0] wb_data;
    riscv_pkg::reg_addr_t       wb_rd;
    logic                       wb_reg_write;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    execute_stage u_execute_stage (.*);

    mem_wb_stage u_mem_wb_stage (.*);

    hazard_unit u_hazard_unit (
        .fetch_instr (instr),
        .*
    );

    // data RAM is driven straight from the memory stage registers
    assign mem_addr       = mem_result;
    assign mem_write_data = mem_rs2;
    assign mem_read_en    = mem_read;
    assign mem_write_en   = mem_write;

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [riscv_pkg::xlen-1:0]  mem_result,
    input  riscv_pkg::mem_wb_sel_t      mem_mem_wb_sel,
    input  logic [riscv_pkg::xlen-1:0]  load_data,
    input  riscv_pkg::reg_addr_t        mem_rd,
    input  logic                        mem_reg_write,
    output logic [riscv_pkg::xlen-1:0]  wb_data,
    output riscv_pkg::reg_addr_t        wb_rd,
    output logic                        wb_reg_write
);

    always_ff @(posedge clk) begin
        wb_data <= (mem_mem_wb_sel == riscv_pkg::mem_wb_load_data) ? load_data : mem_result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rd        <= '0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_rd        <= mem_rd;
            wb_reg_write <= mem_reg_write;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [riscv_pkg::xlen-1:0]  exe_pc,
    input  logic [riscv_pkg::xlen-1:0]  exe_op1,
    input  logic [riscv_pkg::xlen-1:0]  exe_op2,
    input  logic [riscv_pkg::xlen-1:0]  exe_rs2,
    input  riscv_pkg::alu_op_t          exe_alu_op,
    input  riscv_pkg::pc_sel_t          exe_pc_sel,
    input  logic                        exe_is_beq,
    input  logic                        exe_is_bne,
    input  riscv_pkg::exe_wb_sel_t      exe_exe_wb_sel,
    input  riscv_pkg::mem_wb_sel_t      exe_mem_wb_sel,
    input  logic                        exe_reg_write,
    input  logic                        exe_mem_read,
    input  logic                        exe_mem_write,
    input  riscv_pkg::reg_addr_t        exe_rd,
    output logic                        br_taken,
    output logic [riscv_pkg::xlen-1:0]  redirect_pc,
    output logic [riscv_pkg::xlen-1:0]  mem_result,
    output logic [riscv_pkg::xlen-1:0]  mem_rs2,
    output riscv_pkg::reg_addr_t        mem_rd,
    output logic                        mem_reg_write,
    output logic                        mem_read,
    output logic                        mem_write,
    output riscv_pkg::mem_wb_sel_t      mem_mem_wb_sel
);

    logic [riscv_pkg::xlen-1:0] alu_result;
    logic                       br_eq;
    riscv_pkg::pc_sel_t         pc_sel;

    alu u_alu (
        .alu_op (exe_alu_op),
        .op1    (exe_op1),
        .op2    (exe_op2),
        .result (alu_result)
    );

    // op1 holds rs1 for branches
    assign br_eq = exe_op1 == exe_rs2;

    always_comb begin
        pc_sel = exe_pc_sel;
        if ((exe_is_beq && !br_eq) || (exe_is_bne && br_eq)) begin
            pc_sel = riscv_pkg::pc_sel_plus4;
        end
    end

    assign br_taken    = pc_sel != riscv_pkg::pc_sel_plus4;
    assign redirect_pc = (pc_sel == riscv_pkg::pc_sel_jalr) ? ((exe_op1 + exe_op2) & ~32'd1)
                                                            : exe_pc + exe_op2;

    always_ff @(posedge clk) begin
        mem_result <= (exe_exe_wb_sel == riscv_pkg::exe_wb_alu) ? alu_result : exe_pc + 32'd4;
        mem_rs2    <= exe_rs2;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rd         <= '0;
            mem_reg_write  <= 1'b0;
            mem_read       <= 1'b0;
            mem_write      <= 1'b0;
            mem_mem_wb_sel <= '0;
        end else begin
            mem_rd         <= exe_rd;
            mem_reg_write  <= exe_reg_write;
            mem_read       <= exe_mem_read;
            mem_write      <= exe_mem_write;
            mem_mem_wb_sel <= exe_mem_wb_sel;
        end
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [riscv_pkg::xlen-1:0]  dec_pc,
    input  riscv_pkg::instr_t           dec_instr,
    input  logic                        dec_kill,
    input  riscv_pkg::reg_addr_t        wb_rd,
    input  logic                        wb_reg_write,
    input  logic [riscv_pkg::xlen-1:0]  wb_data,
    input  riscv_pkg::reg_addr_t        debug_reg_addr,
    output logic [riscv_pkg::xlen-1:0]  debug_reg_data,
    output riscv_pkg::reg_addr_t        dec_rd,
    output logic                        dec_reg_write,
    output logic [riscv_pkg::xlen-1:0]  exe_pc,
    output logic [riscv_pkg::xlen-1:0]  exe_op1,
    output logic [riscv_pkg::xlen-1:0]  exe_op2,
    output logic [riscv_pkg::xlen-1:0]  exe_rs2,
    output riscv_pkg::alu_op_t          exe_alu_op,
    output riscv_pkg::pc_sel_t          exe_pc_sel,
    output logic                        exe_is_beq,
    output logic                        exe_is_bne,
    output riscv_pkg::exe_wb_sel_t      exe_exe_wb_sel,
    output riscv_pkg::mem_wb_sel_t      exe_mem_wb_sel,
    output logic                        exe_reg_write,
    output logic                        exe_mem_read,
    output logic                        exe_mem_write,
    output riscv_pkg::reg_addr_t        exe_rd
);

    riscv_pkg::alu_op_t         alu_op;
    riscv_pkg::op1_sel_t        op1_sel;
    riscv_pkg::op2_sel_t        op2_sel;
    riscv_pkg::pc_sel_t         pc_sel;
    logic                       is_beq;
    logic                       is_bne;
    riscv_pkg::exe_wb_sel_t     exe_wb_sel;
    riscv_pkg::mem_wb_sel_t     mem_wb_sel;
    logic                       mem_read;
    logic                       mem_write;
    logic [riscv_pkg::xlen-1:0] rs1_data;
    logic [riscv_pkg::xlen-1:0] rs2_data;
    logic [riscv_pkg::xlen-1:0] i_imm;
    logic [riscv_pkg::xlen-1:0] s_imm;
    logic [riscv_pkg::xlen-1:0] b_imm;
    logic [riscv_pkg::xlen-1:0] u_imm;
    logic [riscv_pkg::xlen-1:0] j_imm;
    logic [riscv_pkg::xlen-1:0] op1;
    logic [riscv_pkg::xlen-1:0] op2;

    control_decoder u_control_decoder (
        .instr      (dec_instr),
        .alu_op     (alu_op),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .pc_sel     (pc_sel),
        .is_beq     (is_beq),
        .is_bne     (is_bne),
        .exe_wb_sel (exe_wb_sel),
        .mem_wb_sel (mem_wb_sel),
        .reg_write  (dec_reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs1_addr   (dec_instr.r_fmt.rs1),
        .rs2_addr   (dec_instr.r_fmt.rs2),
        .rd         (wb_rd),
        .rd_data    (wb_data),
        .write_en   (wb_reg_write),
        .debug_addr (debug_reg_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .debug_data (debug_reg_data)
    );

    assign dec_rd = dec_instr.r_fmt.rd;

    // immediates, all sign extended from bit 31
    assign i_imm = {{20{dec_instr.i_fmt.imm12[11]}}, dec_instr.i_fmt.imm12};
    assign s_imm = {{20{dec_instr.s_fmt.imm_hi[6]}}, dec_instr.s_fmt.imm_hi,
                    dec_instr.s_fmt.imm_lo};
    assign b_imm = {{20{dec_instr.s_fmt.imm_hi[6]}}, dec_instr.s_fmt.imm_lo[0],
                    dec_instr.s_fmt.imm_hi[5:0], dec_instr.s_fmt.imm_lo[4:1], 1'b0};
    assign u_imm = {dec_instr[31:12], 12'b0};
    assign j_imm = {{12{dec_instr[31]}}, dec_instr[19:12], dec_instr[20],
                    dec_instr[30:21], 1'b0};

    assign op1 = (op1_sel == riscv_pkg::op1_rs1) ? rs1_data : dec_pc;

    always_comb begin
        case (op2_sel)
            riscv_pkg::op2_i_imm: op2 = i_imm;
            riscv_pkg::op2_s_imm: op2 = s_imm;
            riscv_pkg::op2_b_imm: op2 = b_imm;
            riscv_pkg::op2_u_imm: op2 = u_imm;
            riscv_pkg::op2_j_imm: op2 = j_imm;
            default:              op2 = rs2_data;
        endcase
    end

    always_ff @(posedge clk) begin
        exe_pc  <= dec_pc;
        exe_op1 <= op1;
        exe_op2 <= op2;
        exe_rs2 <= rs2_data;
    end

    // a killed slot carries zero controls into execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_alu_op     <= '0;
            exe_pc_sel     <= '0;
            exe_is_beq     <= 1'b0;
            exe_is_bne     <= 1'b0;
            exe_exe_wb_sel <= '0;
            exe_mem_wb_sel <= '0;
            exe_reg_write  <= 1'b0;
            exe_mem_read   <= 1'b0;
            exe_mem_write  <= 1'b0;
            exe_rd         <= '0;
        end else begin
            exe_alu_op     <= dec_kill ? '0 : alu_op;
            exe_pc_sel     <= dec_kill ? '0 : pc_sel;
            exe_is_beq     <= is_beq && !dec_kill;
            exe_is_bne     <= is_bne && !dec_kill;
            exe_exe_wb_sel <= dec_kill ? '0 : exe_wb_sel;
            exe_mem_wb_sel <= dec_kill ? '0 : mem_wb_sel;
            exe_reg_write  <= dec_reg_write && !dec_kill;
            exe_mem_read   <= mem_read && !dec_kill;
            exe_mem_write  <= mem_write && !dec_kill;
            exe_rd         <= dec_kill ? '0 : dec_rd;
        end
    end

endmodule

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter logic [riscv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  riscv_pkg::instr_t           instr,
    input  logic                        pc_write_en,
    input  logic                        if_kill,
    input  logic                        br_taken,
    input  logic [riscv_pkg::xlen-1:0]  redirect_pc,
    output logic [riscv_pkg::xlen-1:0]  pc,
    output logic [riscv_pkg::xlen-1:0]  dec_pc,
    output riscv_pkg::instr_t           dec_instr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= reset_pc;
            dec_instr <= riscv_pkg::nop_instr;
        end else begin
            if (pc_write_en) begin
                pc <= br_taken ? redirect_pc : pc + 32'd4;
            end
            // killed or stalled slots enter decode as a nop
            dec_instr <= if_kill ? riscv_pkg::nop_instr : instr;
        end
    end

    always_ff @(posedge clk) begin
        dec_pc <= pc;
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  riscv_pkg::instr_t     fetch_instr,
    input  riscv_pkg::reg_addr_t  dec_rd,
    input  logic                  dec_reg_write,
    input  riscv_pkg::reg_addr_t  exe_rd,
    input  logic                  exe_reg_write,
    input  riscv_pkg::reg_addr_t  mem_rd,
    input  logic                  mem_reg_write,
    input  riscv_pkg::reg_addr_t  wb_rd,
    input  logic                  wb_reg_write,
    input  logic                  br_taken,
    output logic                  pc_write_en,
    output logic                  if_kill,
    output logic                  dec_kill
);

    logic stall;

    // rs fields are compared even for formats that lack them
    function automatic logic pending(input riscv_pkg::reg_addr_t rd, input logic reg_write,
                                     input riscv_pkg::instr_t instr);
        return reg_write && rd != '0 && (rd == instr.r_fmt.rs1 || rd == instr.r_fmt.rs2);
    endfunction

    always_comb begin
        stall = pending(dec_rd, dec_reg_write, fetch_instr)
             || pending(exe_rd, exe_reg_write, fetch_instr)
             || pending(mem_rd, mem_reg_write, fetch_instr)
             || pending(wb_rd, wb_reg_write, fetch_instr);
    end

    // a taken branch overrides the stall and moves the pc
    assign pc_write_en = !stall || br_taken;
    assign if_kill     = stall || br_taken;
    assign dec_kill    = br_taken;

endmodule

// File: control_decoder.sv
`timescale 1ns/100ps

module control_decoder (
    input  riscv_pkg::instr_t       instr,
    output riscv_pkg::alu_op_t      alu_op,
    output riscv_pkg::op1_sel_t     op1_sel,
    output riscv_pkg::op2_sel_t     op2_sel,
    output riscv_pkg::pc_sel_t      pc_sel,
    output logic                    is_beq,
    output logic                    is_bne,
    output riscv_pkg::exe_wb_sel_t  exe_wb_sel,
    output riscv_pkg::mem_wb_sel_t  mem_wb_sel,
    output logic                    reg_write,
    output logic                    mem_read,
    output logic                    mem_write
);

    logic [2:0] funct3;

    assign funct3 = instr.r_fmt.funct3;

    always_comb begin
        // all-zero controls act as a nop
        alu_op     = riscv_pkg::alu_add;
        op1_sel    = riscv_pkg::op1_pc;
        op2_sel    = riscv_pkg::op2_rs2;
        pc_sel     = riscv_pkg::pc_sel_plus4;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        exe_wb_sel = riscv_pkg::exe_wb_pc_plus4;
        mem_wb_sel = riscv_pkg::mem_wb_exe_result;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        case (instr.r_fmt.opcode)
            riscv_pkg::opc_op: begin
                alu_op     = {instr.r_fmt.funct7[5], funct3};
                op1_sel    = riscv_pkg::op1_rs1;
                exe_wb_sel = riscv_pkg::exe_wb_alu;
                reg_write  = 1'b1;
            end
            riscv_pkg::opc_op_imm: begin
                // only srai carries funct7[5]; addi has no subtract form
                alu_op     = {funct3 == 3'b101 && instr.r_fmt.funct7[5], funct3};
                op1_sel    = riscv_pkg::op1_rs1;
                op2_sel    = riscv_pkg::op2_i_imm;
                exe_wb_sel = riscv_pkg::exe_wb_alu;
                reg_write  = 1'b1;
            end
            riscv_pkg::opc_lui: begin
                alu_op     = riscv_pkg::alu_copy_op2;
                op2_sel    = riscv_pkg::op2_u_imm;
                exe_wb_sel = riscv_pkg::exe_wb_alu;
                reg_write  = 1'b1;
            end
            riscv_pkg::opc_auipc: begin
                op2_sel    = riscv_pkg::op2_u_imm;
                exe_wb_sel = riscv_pkg::exe_wb_alu;
                reg_write  = 1'b1;
            end
            riscv_pkg::opc_load: begin
                if (funct3 == 3'b010) begin
                    op1_sel    = riscv_pkg::op1_rs1;
                    op2_sel    = riscv_pkg::op2_i_imm;
                    exe_wb_sel = riscv_pkg::exe_wb_alu;
                    mem_wb_sel = riscv_pkg::mem_wb_load_data;
                    reg_write  = 1'b1;
                    mem_read   = 1'b1;
                end
            end
            riscv_pkg::opc_store: begin
                if (funct3 == 3'b010) begin
                    op1_sel    = riscv_pkg::op1_rs1;
                    op2_sel    = riscv_pkg::op2_s_imm;
                    exe_wb_sel = riscv_pkg::exe_wb_alu;
                    mem_write  = 1'b1;
                end
            end
            riscv_pkg::opc_branch: begin
                // beq and bne only, execute drops pc_sel when not taken
                if (funct3[2:1] == 2'b00) begin
                    op1_sel = riscv_pkg::op1_rs1;
                    op2_sel = riscv_pkg::op2_b_imm;
                    pc_sel  = riscv_pkg::pc_sel_br_jal;
                    is_beq  = !funct3[0];
                    is_bne  = funct3[0];
                end
            end
            riscv_pkg::opc_jal: begin
                op2_sel   = riscv_pkg::op2_j_imm;
                pc_sel    = riscv_pkg::pc_sel_br_jal;
                reg_write = 1'b1;
            end
            riscv_pkg::opc_jalr: begin
                op1_sel   = riscv_pkg::op1_rs1;
                op2_sel   = riscv_pkg::op2_i_imm;
                pc_sel    = riscv_pkg::pc_sel_jalr;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  riscv_pkg::reg_addr_t        rs1_addr,
    input  riscv_pkg::reg_addr_t        rs2_addr,
    input  riscv_pkg::reg_addr_t        rd,
    input  logic [riscv_pkg::xlen-1:0]  rd_data,
    input  logic                        write_en,
    input  riscv_pkg::reg_addr_t        debug_addr,
    output logic [riscv_pkg::xlen-1:0]  rs1_data,
    output logic [riscv_pkg::xlen-1:0]  rs2_data,
    output logic [riscv_pkg::xlen-1:0]  debug_data
);

    logic [riscv_pkg::xlen-1:0] regs [32];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data   = regs[rs1_addr];
    assign rs2_data   = regs[rs2_addr];
    assign debug_data = regs[debug_addr];

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu (
    input  riscv_pkg::alu_op_t          alu_op,
    input  logic [riscv_pkg::xlen-1:0]  op1,
    input  logic [riscv_pkg::xlen-1:0]  op2,
    output logic [riscv_pkg::xlen-1:0]  result
);

    always_comb begin
        case (alu_op)
            riscv_pkg::alu_add:  result = op1 + op2;
            riscv_pkg::alu_sub:  result = op1 - op2;
            // shifts only look at the low five bits
            riscv_pkg::alu_sll:  result = op1 << op2[4:0];
            riscv_pkg::alu_srl:  result = op1 >> op2[4:0];
            riscv_pkg::alu_sra:  result = $signed(op1) >>> op2[4:0];
            riscv_pkg::alu_slt:  result = {{(riscv_pkg::xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            riscv_pkg::alu_sltu: result = {{(riscv_pkg::xlen-1){1'b0}}, op1 < op2};
            riscv_pkg::alu_xor:  result = op1 ^ op2;
            riscv_pkg::alu_or:   result = op1 | op2;
            riscv_pkg::alu_and:  result = op1 & op2;
            // lui path
            riscv_pkg::alu_copy_op2: result = op2;
            default: result = op1 + op2;
        endcase
    end

endmodule

// File: riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [3:0] alu_op_t;
    typedef logic       op1_sel_t;
    typedef logic [2:0] op2_sel_t;
    typedef logic [1:0] pc_sel_t;
    typedef logic       exe_wb_sel_t;
    typedef logic       mem_wb_sel_t;

    // low three bits follow funct3, bit 3 follows funct7[5]
    localparam alu_op_t alu_add      = 4'b0000;
    localparam alu_op_t alu_sll      = 4'b0001;
    localparam alu_op_t alu_slt      = 4'b0010;
    localparam alu_op_t alu_sltu     = 4'b0011;
    localparam alu_op_t alu_xor      = 4'b0100;
    localparam alu_op_t alu_srl      = 4'b0101;
    localparam alu_op_t alu_or       = 4'b0110;
    localparam alu_op_t alu_and      = 4'b0111;
    localparam alu_op_t alu_sub      = 4'b1000;
    localparam alu_op_t alu_sra      = 4'b1101;
    localparam alu_op_t alu_copy_op2 = 4'b1111;

    localparam op1_sel_t op1_pc  = 1'b0;
    localparam op1_sel_t op1_rs1 = 1'b1;

    localparam op2_sel_t op2_rs2   = 3'd0;
    localparam op2_sel_t op2_i_imm = 3'd1;
    localparam op2_sel_t op2_s_imm = 3'd2;
    localparam op2_sel_t op2_b_imm = 3'd3;
    localparam op2_sel_t op2_u_imm = 3'd4;
    localparam op2_sel_t op2_j_imm = 3'd5;

    localparam pc_sel_t pc_sel_plus4  = 2'd0;
    localparam pc_sel_t pc_sel_br_jal = 2'd1;
    localparam pc_sel_t pc_sel_jalr   = 2'd2;

    localparam exe_wb_sel_t exe_wb_pc_plus4 = 1'b0;
    localparam exe_wb_sel_t exe_wb_alu      = 1'b1;

    localparam mem_wb_sel_t mem_wb_exe_result = 1'b0;
    localparam mem_wb_sel_t mem_wb_load_data  = 1'b1;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } instr_t;

    // addi x0, x0, 0
    localparam instr_t nop_instr = 32'h0000_0013;

endpackage
